/* compile.f */
+incdir+src
src/key_expand_pkg.sv
src/key_sbox.sv
src/key_loader.sv
src/key_schedule.sv
src/round_key_store.sv
src/key_expand_top.sv
testbench/key_expand_props.sv
testbench/key_expand_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = key_expand_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/key_expand_tb.sv */
`timescale 1ns/1ns
`include "key_expand_params.svh"

module key_expand_tb
    import key_expand_pkg::*;
();

    localparam int RESET_CYCLES  = 16;
    localparam int EXPAND_CYCLES = 60;
    localparam int DONE_LATENCY  = 45;
    localparam int TABLE_LEN     = 16;
    // four expansions, the reset and room for every single-word read
    localparam int MAX_CYCLES = 4 * EXPAND_CYCLES + RESET_CYCLES + 3 * `TOTAL_WORDS;
    localparam logic [127:0] FIPS_KEY = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;

    typedef struct packed {
        logic       key_sel;
        logic [3:0] round;
        logic [1:0] col;
        key_word_t  expected;
    } check_entry_t;

    // key_sel 0 is the first FIPS-197 run, 1 is the run after the restart
    check_entry_t check_table [TABLE_LEN] = '{
        '{1'b0, 4'd0, 2'd0, 32'h2b7e1516}, '{1'b0, 4'd0, 2'd1, 32'h28aed2a6},
        '{1'b0, 4'd0, 2'd2, 32'habf71588}, '{1'b0, 4'd0, 2'd3, 32'h09cf4f3c},
        '{1'b0, 4'd1, 2'd0, 32'ha0fafe17}, '{1'b0, 4'd1, 2'd1, 32'h88542cb1},
        '{1'b0, 4'd1, 2'd2, 32'h23a33939}, '{1'b0, 4'd1, 2'd3, 32'h2a6c7605},
        '{1'b0, 4'd10, 2'd0, 32'hd014f9a8}, '{1'b0, 4'd10, 2'd1, 32'hc9ee2589},
        '{1'b0, 4'd10, 2'd2, 32'he13f0cc8}, '{1'b0, 4'd10, 2'd3, 32'hb6630ca6},
        '{1'b1, 4'd10, 2'd0, 32'hd014f9a8}, '{1'b1, 4'd10, 2'd1, 32'hc9ee2589},
        '{1'b1, 4'd10, 2'd2, 32'he13f0cc8}, '{1'b1, 4'd10, 2'd3, 32'hb6630ca6}
    };

    logic       clk;
    logic       reset;
    logic       start;
    key_word_t  cipher_key;
    logic [3:0] round_key_num;
    logic [1:0] r_index;
    key_word_t  round_key;
    logic       done;

    int          cycle_count = 0;
    int          test_errors;
    int          tests_failed;
    int          total_errors;
    int          test_num;
    logic [31:0] rand_state;
    key_word_t   words [`TOTAL_WORDS];

    key_expand_top key_expand_top_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .cipher_key    (cipher_key),
        .round_key_num (round_key_num),
        .r_index       (r_index),
        .round_key     (round_key),
        .done          (done)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (test_errors == 0) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // start pulse, then the four key words on the next four cycles
    task automatic load_key(input logic [127:0] key);
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        for (int w = 0; w < `KEY_WORDS; w++) begin
            #1 start = 1'b0;
            cipher_key = key[127 - 32*w -: 32];
            @(posedge clk);
        end
        #1 cipher_key = '0;
    endtask

    // counts edges from the one that sampled start
    task automatic wait_done(output int latency);
        latency = `KEY_WORDS;
        while (done !== 1'b1 && latency < 2 * DONE_LATENCY) begin
            @(posedge clk);
            #1 latency++;
        end
        assert (done === 1'b1) else begin
            $display("done did not rise within %0d cycles after start", latency);
            test_errors++;
        end
        check_value("done latency", 32'(latency), 32'(DONE_LATENCY));
    endtask

    task automatic read_word(input int rnd, input int col, output key_word_t word);
        @(posedge clk);
        #1 round_key_num = 4'(rnd);
        r_index = 2'(col);
        @(negedge clk);
        word = round_key;
    endtask

    task automatic apply_table(input logic sel);
        key_word_t got;
        for (int i = 0; i < TABLE_LEN; i++) begin
            if (check_table[i].key_sel == sel) begin
                read_word(int'(check_table[i].round), int'(check_table[i].col), got);
                check_value($sformatf("round_key r%0d c%0d", check_table[i].round,
                            check_table[i].col), got, check_table[i].expected);
            end
        end
    endtask

    task automatic draw_key(output logic [127:0] key);
        for (int w = 0; w < `KEY_WORDS; w++) begin
            rand_state = lcg_next(rand_state);
            key[127 - 32*w -: 32] = rand_state;
        end
    endtask

    initial begin
        key_word_t    got;
        int           latency;
        logic [127:0] rand_key;
        clk           = 1'b0;
        reset         = 1'b1;
        start         = 1'b0;
        cipher_key    = '0;
        round_key_num = '0;
        r_index       = '0;
        rand_state    = 32'h6ef3cefd;
        test_errors   = 0;
        tests_failed  = 0;
        total_errors  = 0;
        test_num      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        check_value("done", 32'(done), 32'd0);
        for (int i = 0; i < `TOTAL_WORDS; i++) begin
            read_word(i / 4, i % 4, got);
            check_value($sformatf("round_key r%0d c%0d", i / 4, i % 4), got, '0);
        end
        end_test("store cleared by reset");

        load_key(FIPS_KEY);
        wait_done(latency);
        end_test("FIPS-197 key done timing");

        apply_table(1'b0);
        end_test("FIPS-197 schedule words");

        draw_key(rand_key);
        load_key(rand_key);
        wait_done(latency);
        for (int i = 0; i < `TOTAL_WORDS; i++) begin
            read_word(i / 4, i % 4, words[i]);
        end
        for (int c = 0; c < `KEY_WORDS; c++) begin
            check_value($sformatf("round_key r0 c%0d", c), words[c], rand_key[127 - 32*c -: 32]);
        end
        // inner columns follow w[i] = w[i-4] ^ w[i-1]
        for (int r = 1; r <= `NUM_ROUNDS; r++) begin
            for (int c = 1; c < `KEY_WORDS; c++) begin
                check_value($sformatf("round_key r%0d c%0d", r, c), words[4*r + c],
                            words[4*(r-1) + c] ^ words[4*r + c - 1]);
            end
        end
        end_test("random key schedule");

        // done is high here, a new start has to clear it
        draw_key(rand_key);
        load_key(rand_key);
        check_value("done", 32'(done), 32'd0);
        // second start is sampled 20 edges after the first one
        repeat (20 - `KEY_WORDS - 2) @(posedge clk);
        load_key(FIPS_KEY);
        check_value("done", 32'(done), 32'd0);
        wait_done(latency);
        apply_table(1'b1);
        end_test("restart during expansion");

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 test_num, test_num - tests_failed, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/key_expand_props.sv */
`timescale 1ns/1ns
`include "key_expand_params.svh"

module key_expand_props
    import key_expand_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        start,
    input word_write_t load_wr,
    input word_write_t expand_wr,
    input logic        done
);

    localparam int LOW_CYCLES = 45;

    // edges since the last start, done has to stay low meanwhile
    logic [5:0] since_start;
    logic       tracking;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_start <= 6'd0;
            tracking    <= 1'b0;
        end else if (start) begin
            since_start <= 6'd0;
            tracking    <= 1'b1;
        end else if (tracking) begin
            if (since_start == 6'(LOW_CYCLES - 1)) begin
                tracking <= 1'b0;
            end
            since_start <= since_start + 6'd1;
        end
    end

    no_write_overlap: assert property (@(posedge clk) disable iff (reset)
        !(load_wr.valid && expand_wr.valid))
        else $error("load and expansion writes are valid in the same cycle");

    done_held_low: assert property (@(posedge clk) disable iff (reset)
        tracking |-> !done)
        else $error("done rose before the expansion could finish");

    // a restart breaks the sequence, so the start cycle is left out
    addr_steps: assert property (@(posedge clk) disable iff (reset)
        (expand_wr.valid && !start && expand_wr.addr != 6'(`TOTAL_WORDS - 1))
        |=> (expand_wr.valid && expand_wr.addr == $past(expand_wr.addr) + 6'd1))
        else $error("expansion write address did not step by one");

endmodule

bind key_schedule key_expand_props key_expand_props_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .load_wr   (load_wr),
    .expand_wr (expand_wr),
    .done      (done)
);

/* src/key_expand_top.sv */
`timescale 1ns/1ns

module key_expand_top
    import key_expand_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  key_word_t  cipher_key,
    input  logic [3:0] round_key_num,
    input  logic [1:0] r_index,
    output key_word_t  round_key,
    output logic       done
);

    word_write_t load_wr;
    word_write_t expand_wr;
    logic        key_loaded;

    key_loader key_loader_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cipher_key (cipher_key),
        .load_wr    (load_wr),
        .key_loaded (key_loaded)
    );

    key_schedule key_schedule_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .load_wr    (load_wr),
        .key_loaded (key_loaded),
        .expand_wr  (expand_wr),
        .done       (done)
    );

    // schedule words land here and are read back by round and column
    round_key_store round_key_store_i (
        .clk           (clk),
        .reset         (reset),
        .load_wr       (load_wr),
        .expand_wr     (expand_wr),
        .round_key_num (round_key_num),
        .r_index       (r_index),
        .round_key     (round_key)
    );

endmodule

/* src/round_key_store.sv */
`timescale 1ns/1ns
`include "key_expand_params.svh"

module round_key_store
    import key_expand_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  word_write_t load_wr,
    input  word_write_t expand_wr,
    input  logic [3:0]  round_key_num,
    input  logic [1:0]  r_index,
    output key_word_t   round_key
);

    key_word_t   mem [`TOTAL_WORDS];
    word_write_t wr;
    key_addr_u   raddr;

    // loading and expansion never overlap, so a plain select does
    assign wr = load_wr.valid ? load_wr : expand_wr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `TOTAL_WORDS; k++) begin
                mem[k] <= '0;
            end
        end else if (wr.valid && (wr.addr < 6'(`TOTAL_WORDS))) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // round and column in, flat word index out
    always_comb begin
        raddr.rc.round = round_key_num;
        raddr.rc.col   = r_index;
        if (round_key_num <= 4'(`NUM_ROUNDS)) begin
            round_key = mem[raddr.index];
        end else begin
            round_key = '0;
        end
    end

endmodule

/* src/key_schedule.sv */
`timescale 1ns/1ns
`include "key_expand_params.svh"

module key_schedule
    import key_expand_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  word_write_t load_wr,
    input  logic        key_loaded,
    output word_write_t expand_wr,
    output logic        done
);

    // window[0] is word i-4, window[KEY_WORDS-1] is word i-1
    key_word_t  window [`KEY_WORDS];
    logic [5:0] count;
    logic [7:0] rcon;
    logic       running;

    key_word_t  prev_word;
    key_word_t  rot_word;
    key_word_t  sub_word;
    key_word_t  temp_word;
    key_word_t  next_word;
    logic       rcon_step;

    assign prev_word = window[`KEY_WORDS-1];
    assign rot_word  = {prev_word[23:0], prev_word[31:24]};

    // SubWord, one S-box per byte
    for (genvar i = 0; i < 4; i++) begin : g_sbox
        key_sbox sbox_i (
            .byte_in  (rot_word[8*i +: 8]),
            .byte_out (sub_word[8*i +: 8])
        );
    end

    // every fourth word takes the rotated, substituted path
    assign rcon_step = (count[1:0] == 2'd0);

    always_comb begin
        if (rcon_step) begin
            temp_word = sub_word ^ {rcon, 24'h000000};
        end else begin
            temp_word = prev_word;
        end
        next_word = window[0] ^ temp_word;
    end

    always_comb begin
        expand_wr.valid = running && (count != 6'(`TOTAL_WORDS));
        expand_wr.addr  = count;
        expand_wr.data  = next_word;
    end

    // loaded words and new words both shift into the window
    always_ff @(posedge clk) begin
        if (load_wr.valid || expand_wr.valid) begin
            for (int k = 0; k < `KEY_WORDS - 1; k++) begin
                window[k] <= window[k+1];
            end
            window[`KEY_WORDS-1] <= load_wr.valid ? load_wr.data : next_word;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            count   <= 6'd0;
            rcon    <= 8'h00;
            done    <= 1'b0;
        end else if (start) begin
            // restart drops any expansion in progress
            running <= 1'b0;
            done    <= 1'b0;
        end else if (key_loaded) begin
            running <= 1'b1;
            count   <= 6'(`KEY_WORDS);
            rcon    <= `RCON_FIRST;
        end else if (running) begin
            if (count == 6'(`TOTAL_WORDS)) begin
                // word 43 landed on the previous edge
                running <= 1'b0;
                done    <= 1'b1;
            end else begin
                count <= count + 6'd1;
                if (rcon_step) begin
                    // xtime in GF(2^8)
                    rcon <= {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
                end
            end
        end
    end

endmodule

/* src/key_loader.sv */
`timescale 1ns/1ns
`include "key_expand_params.svh"

module key_loader
    import key_expand_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  key_word_t   cipher_key,
    output word_write_t load_wr,
    output logic        key_loaded
);

    logic [1:0] count;
    logic       loading;

    // four key words follow the start pulse, one per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= 2'd0;
            loading <= 1'b0;
        end else if (start) begin
            count   <= 2'd0;
            loading <= 1'b1;
        end else if (loading) begin
            if (count == 2'(`KEY_WORDS - 1)) begin
                loading <= 1'b0;
            end
            count <= count + 2'd1;
        end
    end

    // word index is the counter, data comes straight from the input
    always_comb begin
        load_wr.valid = loading;
        load_wr.addr  = {4'd0, count};
        load_wr.data  = cipher_key;
        key_loaded    = loading && (count == 2'(`KEY_WORDS - 1));
    end

endmodule

/* src/key_sbox.sv */
`timescale 1ns/1ns

module key_sbox (
    input  logic [7:0] byte_in,
    output logic [7:0] byte_out
);

    // one row of the table, selected by the high nibble
    logic [127:0] row;

    // AES forward S-box, 16 entries per row, entry 0 in the top byte
    always_comb begin
        case (byte_in[7:4])
            4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
            4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
            4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
            4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
            4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
            4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
            4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
            4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
            4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
            4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
            4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
            4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
            4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
            4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
            4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
            4'hf: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
            default: row = '0;
        endcase
    end

    // low nibble picks the byte, counting from the top of the row
    always_comb begin
        byte_out = row[8*(15 - byte_in[3:0]) +: 8];
    end

endmodule

/* src/key_expand_pkg.sv */
`include "key_expand_params.svh"

package key_expand_pkg;

    // one schedule word
    typedef logic [`WORD_W-1:0] key_word_t;

    // write record sent to the word store
    typedef struct packed {
        logic       valid;
        logic [5:0] addr;
        key_word_t  data;
    } word_write_t;

    // word address, seen flat or as round and column
    // round * 4 + column is the flat index
    typedef union packed {
        logic [5:0] index;
        struct packed {
            logic [3:0] round;
            logic [1:0] col;
        } rc;
    } key_addr_u;

endpackage

/* src/key_expand_params.svh */
`ifndef KEY_EXPAND_PARAMS_SVH
`define KEY_EXPAND_PARAMS_SVH

// width of one schedule word
`define WORD_W 32

// AES-128 key and schedule sizes
`define KEY_WORDS 4
`define TOTAL_WORDS 44
`define NUM_ROUNDS 10

// round constant for word 4
`define RCON_FIRST 8'h01

`endif
